// File: vlog.f
+incdir+include
rtl/eeprom_pkg.sv
rtl/bus_sampler.sv
rtl/byte_shifter.sv
rtl/eeprom_ctrl.sv
rtl/eeprom_array.sv
rtl/eeprom_top.sv
bench/eeprom_tb.sv

// File: run.sh
#!/bin/sh
# build and run the EEPROM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module eeprom_tb -f vlog.f

out=$(./obj_dir/Veeprom_tb)
echo "$out"

# exit status follows the search for the pass line
echo "$out" | grep -qxF '** PASS **'

// File: bench/eeprom_tb.sv
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_SIZE = 1 << `EE_MEM_AW;
    localparam int BIT_CYC = 16;

    // transaction counts and the worst bit count of each kind
    localparam int N_FILL = 8;
    localparam int N_WR = 40;
    localparam int N_RD = 30;
    localparam int N_SEQ = 20;
    localparam int N_MISC = 12;
    localparam int FILL_BITS = 258 * 9 + 8;
    localparam int WR_BITS = 6 * 9 + 8;
    localparam int RD_BITS = 4 * 9 + 12;
    localparam int SEQ_BITS = 8 * 9 + 12;
    localparam int LIMIT = 2 * BIT_CYC * (N_FILL * FILL_BITS + N_WR * WR_BITS
                           + N_RD * RD_BITS + (N_SEQ + N_MISC) * SEQ_BITS);

    logic        scl;
    logic        rst;
    logic        scl_m;
    logic        sda_m;
    logic        sda_drive;
    wire         bus_sda;
    logic [15:0] lfsr_state;
    logic [7:0]  model [0:MEM_SIZE-1];
    logic [7:0]  wbuf [0:255];
    int          data_errs;
    int          ack_errs;
    int          cycle_cnt;

    // open-drain line, the device can only pull low
    assign bus_sda = sda_m & ~sda_drive;

    eeprom_top dut0 (
        .scl       (scl),
        .rst       (rst),
        .bus_clock (scl_m),
        .bus_data  (bus_sda),
        .sda_drive (sda_drive)
    );

    initial
    begin
        scl = 1'b0;
        forever #50 scl = ~scl;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ ({5'b0, a[10:8]} * 8'h25);
    endfunction

    function automatic logic [7:0] device_byte(input logic [2:0] blk, input logic rd);
        return {`EE_DEV_TYPE, blk, rd};
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge scl);
    endtask

    // entered with the clock low, leaves it low; 16 cycles per bit
    task automatic bit_cycle(input logic b, output logic s);
        tick(2);
        sda_m <= b;
        tick(6);
        scl_m <= 1'b1;
        tick(4);
        s = bus_sda;
        tick(4);
        scl_m <= 1'b0;
    endtask

    // works from idle and as a repeated start
    task automatic bus_start();
        tick(2);
        sda_m <= 1'b1;
        tick(6);
        scl_m <= 1'b1;
        tick(8);
        sda_m <= 1'b0;
        tick(8);
        scl_m <= 1'b0;
    endtask

    task automatic bus_stop();
        tick(2);
        sda_m <= 1'b0;
        tick(6);
        scl_m <= 1'b1;
        tick(8);
        sda_m <= 1'b1;
        tick(8);
    endtask

    task automatic send_byte(input logic [7:0] b, output logic ack);
        logic s;
        for (int i = 7; i >= 0; i--)
            bit_cycle(b[i], s);
        bit_cycle(1'b1, ack);
    endtask

    // last byte gets a no-acknowledge from the master
    task automatic recv_byte(input logic last, output logic [7:0] b);
        logic s;
        b = '0;
        for (int i = 0; i < 8; i++)
        begin
            bit_cycle(1'b1, s);
            b = {b[6:0], s};
        end
        bit_cycle(last, s);
    endtask

    task automatic check_ack(input logic ack, input string what);
        assert (ack === 1'b0)
        else
        begin
            $display("the device did not acknowledge the %s byte", what);
            ack_errs++;
        end
    endtask

    task automatic check_nack(input logic ack);
        assert (ack === 1'b1)
        else
        begin
            $display("the device acknowledged a device byte with a wrong type code");
            ack_errs++;
        end
    endtask

    task automatic check_data(input logic [10:0] addr, input logic [7:0] got);
        logic [7:0] exp;
        exp = model[addr];
        assert (got === exp)
        else
        begin
            $display("Fail bus_data at %h: expected %h, got %h", addr, exp, got);
            data_errs++;
        end
    endtask

    task automatic write_burst(input logic [2:0] blk, input logic [7:0] word, input int n);
        logic       ack;
        logic [7:0] w;
        w = word;
        bus_start();
        send_byte(device_byte(blk, 1'b0), ack);
        check_ack(ack, "device");
        send_byte(word, ack);
        check_ack(ack, "word address");
        for (int i = 0; i < n; i++)
        begin
            send_byte(wbuf[i], ack);
            check_ack(ack, "write data");
            model[{blk, w}] = wbuf[i];
            // wraps inside the block
            w = w + 8'd1;
        end
        bus_stop();
    endtask

    // dummy write, repeated start, then n bytes
    task automatic read_seq(input logic [10:0] addr, input int n);
        logic        ack;
        logic [7:0]  got;
        logic [10:0] a;
        a = addr;
        bus_start();
        send_byte(device_byte(addr[10:8], 1'b0), ack);
        check_ack(ack, "device");
        send_byte(addr[7:0], ack);
        check_ack(ack, "word address");
        bus_start();
        send_byte(device_byte(addr[10:8], 1'b1), ack);
        check_ack(ack, "read device");
        for (int i = 0; i < n; i++)
        begin
            recv_byte(i == n - 1, got);
            check_data(a, got);
            a = a + 11'd1;
        end
        bus_stop();
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < LIMIT)
        begin
            @(posedge scl);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout after %0d cycles, the bus master never finished", cycle_cnt);
        $display("errors: data %0d, acknowledge %0d", data_errs, ack_errs);
        $display("** FAIL **");
        $finish;
    end

    initial
    begin
        logic [2:0] blk;
        logic [7:0] word;
        logic       ack;
        logic       s;
        int         n;

        rst = 1'b1;
        scl_m = 1'b1;
        sda_m = 1'b1;
        lfsr_state = 16'd74;
        data_errs = 0;
        ack_errs = 0;
        tick(10);
        rst <= 1'b0;
        tick(4);

        // every location gets a known value first
        for (int b = 0; b < N_FILL; b++)
        begin
            for (int i = 0; i < 256; i++)
                wbuf[i] = fill_byte({3'(b), 8'(i)});
            write_burst(3'(b), 8'h00, 256);
        end

        for (int k = 0; k < N_WR; k++)
        begin
            blk = 3'(take_bits(3));
            word = 8'(take_bits(8));
            n = 1 + int'(take_bits(2));
            for (int i = 0; i < n; i++)
                wbuf[i] = 8'(take_bits(8));
            write_burst(blk, word, n);
        end

        for (int k = 0; k < N_RD; k++)
            read_seq(11'(take_bits(11)), 1);

        // top of the array rolls over to 0
        read_seq(11'h7FE, 4);
        for (int k = 1; k < N_SEQ; k++)
        begin
            n = 2 + int'(take_bits(2));
            read_seq(11'(take_bits(11)), n);
        end

        // burst across word 255
        blk = 3'(take_bits(3));
        for (int i = 0; i < 4; i++)
            wbuf[i] = 8'(take_bits(8));
        write_burst(blk, 8'hFE, 4);
        read_seq({blk, 8'hFF}, 1);
        read_seq({blk, 8'h00}, 1);

        bus_start();
        send_byte({4'b1011, 3'd0, 1'b0}, ack);
        check_nack(ack);
        bus_stop();

        // stop after three bits of the second data byte
        blk = 3'(take_bits(3));
        word = 8'(take_bits(8));
        wbuf[0] = 8'(take_bits(8));
        bus_start();
        send_byte(device_byte(blk, 1'b0), ack);
        check_ack(ack, "device");
        send_byte(word, ack);
        check_ack(ack, "word address");
        send_byte(wbuf[0], ack);
        check_ack(ack, "write data");
        model[{blk, word}] = wbuf[0];
        for (int i = 0; i < 3; i++)
            bit_cycle(1'(take_bits(1)), s);
        bus_stop();
        read_seq({blk, word}, 1);
        read_seq({blk, word + 8'd1}, 1);

        blk = 3'(take_bits(3));
        word = 8'(take_bits(8));
        wbuf[0] = 8'(take_bits(8));
        wbuf[1] = 8'(take_bits(8));
        write_burst(blk, word, 2);
        read_seq({blk, word}, 1);
        read_seq({blk, word + 8'd1}, 1);

        $display("errors: data %0d, acknowledge %0d", data_errs, ack_errs);
        if (data_errs == 0 && ack_errs == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/eeprom_top.sv
`default_nettype none

module eeprom_top (
    input  wire  scl,
    input  wire  rst,
    input  wire  bus_clock,
    input  wire  bus_data,
    output logic sda_drive
);

    import eeprom_pkg::*;

    bus_event_t events;
    shift_cmd_t cmd;
    mem_req_t   req;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       ack_slot;
    logic       ack_bit;
    logic       req_valid;
    logic       req_ready;
    logic [7:0] rsp_data;
    logic       rsp_valid;
    logic       rsp_ready;

    // bus_data already carries the device pull-down, merged outside
    bus_sampler u_sampler (
        .scl       (scl),
        .rst       (rst),
        .bus_clock (bus_clock),
        .bus_data  (bus_data),
        .events    (events)
    );

    byte_shifter u_shifter (
        .scl       (scl),
        .rst       (rst),
        .events    (events),
        .cmd       (cmd),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .ack_slot  (ack_slot),
        .ack_bit   (ack_bit),
        .sda_drive (sda_drive)
    );

    eeprom_ctrl u_ctrl (
        .scl       (scl),
        .rst       (rst),
        .events    (events),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .ack_slot  (ack_slot),
        .ack_bit   (ack_bit),
        .cmd       (cmd),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_data  (rsp_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    eeprom_array u_array (
        .scl       (scl),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp_data  (rsp_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

endmodule

`default_nettype wire

// File: rtl/eeprom_array.sv
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_array (
    input  wire                     scl,
    input  wire                     rst,
    input  eeprom_pkg::mem_req_t    req,
    input  wire                     req_valid,
    output logic                    req_ready,
    output logic [7:0]              rsp_data,
    output logic                    rsp_valid,
    input  wire                     rsp_ready
);

    import eeprom_pkg::*;

    localparam int DEPTH = 1 << `EE_MEM_AW;

    logic [7:0] mem [0:DEPTH-1];
    logic       accept;

    // no new request while read data waits
    assign req_ready = ~rsp_valid;
    assign accept    = req_valid & req_ready;

    always_ff @(posedge scl)
    begin
        if (accept)
        begin
            if (req.op == mem_write)
                mem[req.addr] <= req.wdata;
            else
                rsp_data <= mem[req.addr];
        end
    end

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            rsp_valid <= 1'b0;
        end
        else if (accept && req.op == mem_read)
        begin
            rsp_valid <= 1'b1;
        end
        else if (rsp_valid && rsp_ready)
        begin
            rsp_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/eeprom_ctrl.sv
`default_nettype none

`include "eeprom_consts.svh"

module eeprom_ctrl (
    input  wire                     scl,
    input  wire                     rst,
    input  eeprom_pkg::bus_event_t  events,
    input  wire [7:0]               rx_byte,
    input  wire                     rx_valid,
    input  wire                     ack_slot,
    input  wire                     ack_bit,
    output eeprom_pkg::shift_cmd_t  cmd,
    output eeprom_pkg::mem_req_t    req,
    output logic                    req_valid,
    input  wire                     req_ready,
    input  wire [7:0]               rsp_data,
    input  wire                     rsp_valid,
    output logic                    rsp_ready
);

    import eeprom_pkg::*;

    localparam int BW = `EE_MEM_AW - `EE_WORD_AW;

    ctrl_state_e            state;
    logic [BW-1:0]          block;
    logic [`EE_WORD_AW-1:0] word;
    logic                   rd_wr;
    logic [`EE_MEM_AW-1:0]  cur_addr;
    logic [`EE_MEM_AW-1:0]  next_addr;

    assign cur_addr  = {block, word};
    // sequential reads wrap over the whole array
    assign next_addr = cur_addr + 1'b1;

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            state     <= idle;
            cmd       <= '0;
            req       <= '0;
            req_valid <= 1'b0;
            rsp_ready <= 1'b0;
            block     <= '0;
            word      <= '0;
            rd_wr     <= 1'b0;
        end
        else
        begin
            cmd.load        <= 1'b0;
            cmd.ack_drive   <= 1'b0;
            cmd.release_bus <= 1'b0;
            // drain a stale read response after an aborted fetch
            rsp_ready <= rsp_valid && !rsp_ready && (state != rd_fetch);

            if (req_valid && req_ready)
            begin
                req_valid <= 1'b0;
                // write address wraps inside the block
                if (req.op == mem_write)
                    word <= word + 1'b1;
            end

            if (events.stop)
            begin
                state           <= idle;
                cmd.release_bus <= 1'b1;
            end
            else if (events.start)
            begin
                state           <= dev_byte;
                cmd.release_bus <= 1'b1;
            end
            else
            begin
                case (state)
                    idle:
                    begin
                    end
                    dev_byte:
                    begin
                        if (rx_valid)
                        begin
                            if (rx_byte[7:4] == `EE_DEV_TYPE)
                            begin
                                block         <= rx_byte[3:1];
                                rd_wr         <= rx_byte[0];
                                cmd.ack_drive <= 1'b1;
                                state         <= dev_ack;
                            end
                            else
                            begin
                                state <= idle;
                            end
                        end
                    end
                    dev_ack:
                    begin
                        if (ack_slot)
                        begin
                            if (rd_wr)
                            begin
                                req       <= '{op: mem_read, addr: cur_addr, wdata: 8'h00};
                                req_valid <= 1'b1;
                                state     <= rd_fetch;
                            end
                            else
                            begin
                                state <= addr_byte;
                            end
                        end
                    end
                    addr_byte:
                    begin
                        if (rx_valid)
                        begin
                            word          <= rx_byte;
                            cmd.ack_drive <= 1'b1;
                            state         <= addr_ack;
                        end
                    end
                    addr_ack:
                    begin
                        if (ack_slot)
                            state <= wr_byte;
                    end
                    wr_byte:
                    begin
                        if (rx_valid)
                        begin
                            req           <= '{op: mem_write, addr: cur_addr, wdata: rx_byte};
                            req_valid     <= 1'b1;
                            cmd.ack_drive <= 1'b1;
                            state         <= wr_ack;
                        end
                    end
                    wr_ack:
                    begin
                        if (ack_slot)
                            state <= wr_byte;
                    end
                    rd_fetch:
                    begin
                        if (rsp_valid)
                        begin
                            cmd.load    <= 1'b1;
                            cmd.tx_byte <= rsp_data;
                            rsp_ready   <= 1'b1;
                            state       <= rd_byte;
                        end
                    end
                    rd_byte:
                    begin
                        // own bits come back through the receiver
                        if (rx_valid)
                            state <= rd_ack;
                    end
                    rd_ack:
                    begin
                        if (ack_slot)
                        begin
                            if (!ack_bit)
                            begin
                                {block, word} <= next_addr;
                                req       <= '{op: mem_read, addr: next_addr, wdata: 8'h00};
                                req_valid <= 1'b1;
                                state     <= rd_fetch;
                            end
                            else
                            begin
                                cmd.release_bus <= 1'b1;
                                state           <= idle;
                            end
                        end
                    end
                    default:
                    begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/byte_shifter.sv
`default_nettype none

module byte_shifter (
    input  wire                     scl,
    input  wire                     rst,
    input  eeprom_pkg::bus_event_t  events,
    input  eeprom_pkg::shift_cmd_t  cmd,
    output logic [7:0]              rx_byte,
    output logic                    rx_valid,
    output logic                    ack_slot,
    output logic                    ack_bit,
    output logic                    sda_drive
);

    // 0..7 data bits, 8 is the ninth clock
    logic [3:0] bit_cnt;
    logic [7:0] tx_shift;
    logic       tx_armed;
    logic       tx_active;
    logic       ack_pend;
    logic       tx_first;
    logic       tx_next;
    logic       tx_step;

    assign tx_first = events.clk_fall && (bit_cnt == 4'd0) && tx_armed;
    assign tx_next  = events.clk_fall && (bit_cnt != 4'd0) && (bit_cnt != 4'd8) && tx_active;
    assign tx_step  = tx_first || tx_next;

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            bit_cnt   <= 4'd0;
            rx_valid  <= 1'b0;
            ack_slot  <= 1'b0;
            ack_bit   <= 1'b1;
            sda_drive <= 1'b0;
            tx_armed  <= 1'b0;
            tx_active <= 1'b0;
            ack_pend  <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            ack_slot <= 1'b0;

            if (events.start || events.stop)
            begin
                bit_cnt <= 4'd0;
            end
            else if (events.clk_rise)
            begin
                if (bit_cnt == 4'd8)
                begin
                    ack_slot <= 1'b1;
                    ack_bit  <= events.data;
                    bit_cnt  <= 4'd0;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (bit_cnt == 4'd7)
                        rx_valid <= 1'b1;
                end
            end

            if (cmd.release_bus)
            begin
                sda_drive <= 1'b0;
                tx_armed  <= 1'b0;
                tx_active <= 1'b0;
                ack_pend  <= 1'b0;
            end
            else
            begin
                if (cmd.load)
                    tx_armed <= 1'b1;
                if (cmd.ack_drive)
                    ack_pend <= 1'b1;

                if (events.clk_fall)
                begin
                    if (bit_cnt == 4'd8)
                    begin
                        // ninth clock belongs to the acknowledge
                        sda_drive <= ack_pend;
                        ack_pend  <= 1'b0;
                        tx_active <= 1'b0;
                    end
                    else if (tx_first)
                    begin
                        sda_drive <= ~tx_shift[7];
                        tx_armed  <= 1'b0;
                        tx_active <= 1'b1;
                    end
                    else if (tx_next)
                    begin
                        sda_drive <= ~tx_shift[7];
                    end
                    else
                    begin
                        sda_drive <= 1'b0;
                    end
                end
            end
        end
    end

    // shift registers, msb first both ways
    always_ff @(posedge scl)
    begin
        if (events.clk_rise && bit_cnt != 4'd8)
            rx_byte <= {rx_byte[6:0], events.data};

        if (cmd.load)
            tx_shift <= cmd.tx_byte;
        else if (tx_step)
            tx_shift <= {tx_shift[6:0], 1'b1};
    end

endmodule

`default_nettype wire

// File: rtl/bus_sampler.sv
`default_nettype none

`include "eeprom_consts.svh"

module bus_sampler (
    input  wire                     scl,
    input  wire                     rst,
    input  wire                     bus_clock,
    input  wire                     bus_data,
    output eeprom_pkg::bus_event_t  events
);

    localparam int N = `EE_SYNC_STAGES;

    logic [N-1:0] clk_sync;
    logic [N-1:0] data_sync;
    logic         clk_q;
    logic         data_q;
    logic         clk_s;
    logic         data_s;

    assign clk_s  = clk_sync[N-1];
    assign data_s = data_sync[N-1];

    // lines idle high, so the chain starts out high
    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            clk_sync  <= '1;
            data_sync <= '1;
            clk_q     <= 1'b1;
            data_q    <= 1'b1;
        end
        else
        begin
            clk_sync  <= {clk_sync[N-2:0], bus_clock};
            data_sync <= {data_sync[N-2:0], bus_data};
            clk_q     <= clk_s;
            data_q    <= data_s;
        end
    end

    always_ff @(posedge scl)
    begin
        if (rst)
        begin
            events <= '0;
        end
        else
        begin
            events.clk_rise <= clk_s & ~clk_q;
            events.clk_fall <= ~clk_s & clk_q;
            // data moving while the clock stays high
            events.start    <= clk_s & clk_q & data_q & ~data_s;
            events.stop     <= clk_s & clk_q & ~data_q & data_s;
            events.data     <= data_s;
        end
    end

endmodule

`default_nettype wire

// File: rtl/eeprom_pkg.sv
`default_nettype none

`include "eeprom_consts.svh"

package eeprom_pkg;

    typedef enum logic [3:0] {
        idle,
        dev_byte,
        dev_ack,
        addr_byte,
        addr_ack,
        wr_byte,
        wr_ack,
        rd_fetch,
        rd_byte,
        rd_ack
    } ctrl_state_e;

    typedef enum logic {
        mem_read,
        mem_write
    } mem_op_e;

    // one scl cycle pulses, data is the synchronized line level
    typedef struct packed {
        logic clk_rise;
        logic clk_fall;
        logic start;
        logic stop;
        logic data;
    } bus_event_t;

    typedef struct packed {
        mem_op_e                 op;
        logic [`EE_MEM_AW-1:0]   addr;
        logic [7:0]              wdata;
    } mem_req_t;

    // release_bus drops every pending or active drive
    typedef struct packed {
        logic       load;
        logic [7:0] tx_byte;
        logic       ack_drive;
        logic       release_bus;
    } shift_cmd_t;

endpackage

`default_nettype wire

// File: include/eeprom_consts.svh
`ifndef EEPROM_CONSTS_SVH
`define EEPROM_CONSTS_SVH

// full array address, block select on top of the word address
`define EE_MEM_AW 11

// word address inside one 256 byte block
`define EE_WORD_AW 8

// upper nibble of a device byte that selects this part
`define EE_DEV_TYPE 4'b1010

// flops per bus line before edge detection
`define EE_SYNC_STAGES 2

`endif
